/* src/core_cfg_pkg.sv */
// ---------------------------------------------------------
// Core-wide widths and the address and instruction types
// Import wherever addresses or instructions are handled
// ---------------------------------------------------------

package core_cfg_pkg;

  // ---------------------------------------------------------
  // Widths
  // ---------------------------------------------------------

  // Address and data path width
  localparam int unsigned XLEN = 64;

  // Uncompressed instructions only
  localparam int unsigned ILEN = 32;

  // Sequential fetch step in bytes
  localparam int unsigned ILEN_BYTES = ILEN / 8;

  // ---------------------------------------------------------
  // Vector types
  // ---------------------------------------------------------

  typedef logic [XLEN-1:0] addr_t;
  typedef logic [ILEN-1:0] instr_t;

  // First fetch address out of reset
  localparam addr_t BOOT_PC = 64'h0000_0000_8000_0000;

endpackage

/* src/fetch_pkg.sv */
// ---------------------------------------------------------
// Fetch front end types, predictor and queue sizing
// Shared by the fetch blocks and the top-level ports
// ---------------------------------------------------------

package fetch_pkg;

  // Predictor geometry
  localparam int unsigned BP_ENTRIES = 16;
  localparam int unsigned BP_IDX_W   = $clog2(BP_ENTRIES);
  // Index sits above the byte offset of a 32-bit word
  localparam int unsigned BP_IDX_LSB = 2;

  // Queue geometry, also the limit on outstanding requests
  localparam int unsigned IQ_DEPTH = 4;
  localparam int unsigned IQ_PTR_W = $clog2(IQ_DEPTH);
  localparam int unsigned IQ_CNT_W = $clog2(IQ_DEPTH + 1);

  typedef logic [BP_IDX_W-1:0] bp_idx_t;
  typedef logic [1:0]          bp_cnt_t;
  typedef logic [IQ_PTR_W-1:0] iq_ptr_t;
  typedef logic [IQ_CNT_W-1:0] iq_cnt_t;

  // Counters start weakly not taken
  localparam bp_cnt_t BP_CNT_INIT = 2'b01;

  // Branch unit resolution
  typedef struct packed {
    core_cfg_pkg::addr_t pc;
    core_cfg_pkg::addr_t target;
    logic                taken;
    logic                mispredict;
  } resolution_t;

  // Prediction attached to each fetched word
  typedef struct packed {
    logic                taken;
    core_cfg_pkg::addr_t target;
  } pred_t;

  // Entry handed to decode
  typedef struct packed {
    core_cfg_pkg::addr_t  pc;
    core_cfg_pkg::instr_t instr;
    pred_t                pred;
  } fetch_entry_t;

  typedef enum logic [1:0] {
    FETCH,
    STALL,
    DRAIN
  } fetch_state_e;

endpackage

/* src/pc_gen.sv */
// ---------------------------------------------------------
// Program counter with the redirect priority selector
// Steps on each accepted request, reloads on a flush
// ---------------------------------------------------------

`timescale 1ns/10ps

module pc_gen (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   comm_except_raised_i,
  input  core_cfg_pkg::addr_t    comm_except_pc_i,
  input  logic                   bu_res_valid_i,
  input  fetch_pkg::resolution_t bu_res_i,
  input  fetch_pkg::pred_t       pred_i,
  input  logic                   step_i,
  input  logic                   mem_ready_i,
  output logic                   valid_o,
  output logic                   bu_ready_o,
  output core_cfg_pkg::addr_t    pc_o
);

  import core_cfg_pkg::*;

  logic  mispredict;
  logic  flush;
  addr_t seq_base;
  addr_t seq_pc;
  addr_t next_pc;

  // Redirect sources
  assign mispredict = bu_res_valid_i & bu_res_i.mispredict;
  assign flush      = comm_except_raised_i | mispredict;

  // ---------------------------------------------------------
  // Next address
  // ---------------------------------------------------------

  // One adder serves both pc+4 and branch pc+4
  assign seq_base = mispredict ? bu_res_i.pc : pc_o;
  assign seq_pc   = seq_base + addr_t'(ILEN_BYTES);

  // Exception, then mispredict, then prediction, then sequential
  always_comb begin : next_pc_sel
    if (comm_except_raised_i) begin
      next_pc = comm_except_pc_i;
    end else if (mispredict) begin
      // Not-taken mispredict resumes after the branch
      next_pc = bu_res_i.taken ? bu_res_i.target : seq_pc;
    end else if (pred_i.taken) begin
      next_pc = pred_i.target;
    end else begin
      next_pc = seq_pc;
    end
  end

  // PC register
  always_ff @(posedge clk_i or negedge rst_ni) begin : pc_reg
    if (!rst_ni) begin
      pc_o <= BOOT_PC;
    end else if (flush || step_i) begin
      pc_o <= next_pc;
    end
  end

  // Current pc is stale during a redirect
  assign valid_o    = ~flush;
  assign bu_ready_o = mem_ready_i;

endmodule

/* src/branch_pred.sv */
// ---------------------------------------------------------
// Direct-mapped branch predictor with 2-bit counters
// Lookup is combinational, training lands one cycle later
// ---------------------------------------------------------

`timescale 1ns/10ps

module branch_pred (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  core_cfg_pkg::addr_t    pc_i,
  output fetch_pkg::pred_t       pred_o,
  input  logic                   bu_res_valid_i,
  input  fetch_pkg::resolution_t bu_res_i
);

  import core_cfg_pkg::*;
  import fetch_pkg::*;

  // Table state
  bp_cnt_t [BP_ENTRIES-1:0] cnt_q;
  logic    [BP_ENTRIES-1:0] valid_q;
  addr_t                    target_q [BP_ENTRIES];

  bp_idx_t rd_idx;
  bp_idx_t wr_idx;
  bp_cnt_t wr_cnt;
  bp_cnt_t cnt_next;

  // Word index for lookup and for training
  assign rd_idx = pc_i[BP_IDX_LSB +: BP_IDX_W];
  assign wr_idx = bu_res_i.pc[BP_IDX_LSB +: BP_IDX_W];

  // ---------------------------------------------------------
  // Lookup
  // ---------------------------------------------------------

  // Taken needs a valid entry and the counter's upper bit
  assign pred_o.taken  = valid_q[rd_idx] & cnt_q[rd_idx][1];
  // Invalid entries report a zero target
  assign pred_o.target = valid_q[rd_idx] ? target_q[rd_idx] : '0;

  // ---------------------------------------------------------
  // Training
  // ---------------------------------------------------------

  assign wr_cnt = cnt_q[wr_idx];

  // Saturating up on taken, down on not taken
  always_comb begin : cnt_update
    cnt_next = wr_cnt;
    if (bu_res_i.taken) begin
      if (wr_cnt != 2'b11) begin
        cnt_next = wr_cnt + 2'd1;
      end
    end else if (wr_cnt != 2'b00) begin
      cnt_next = wr_cnt - 2'd1;
    end
  end

  // Counters and valid bits
  always_ff @(posedge clk_i or negedge rst_ni) begin : ctrl_reg
    if (!rst_ni) begin
      cnt_q   <= {BP_ENTRIES{BP_CNT_INIT}};
      valid_q <= '0;
    end else if (bu_res_valid_i) begin
      cnt_q[wr_idx] <= cnt_next;
      if (bu_res_i.taken) begin
        valid_q[wr_idx] <= 1'b1;
      end
    end
  end

  // Targets only change on a taken resolution
  always_ff @(posedge clk_i) begin : target_reg
    if (bu_res_valid_i && bu_res_i.taken) begin
      target_q[wr_idx] <= bu_res_i.target;
    end
  end

endmodule

/* src/fetch_fsm.sv */
// ---------------------------------------------------------
// Fetch control FSM gating request issue
// Stalls on a full queue, drains squashed responses
// ---------------------------------------------------------

`timescale 1ns/10ps

module fetch_fsm (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic flush_i,
  input  logic queue_full_i,
  input  logic squash_i,
  output logic issue_ok_o
);

  import fetch_pkg::*;

  fetch_state_e state_q;
  fetch_state_e state_d;

  // ---------------------------------------------------------
  // Next state
  // ---------------------------------------------------------

  always_comb begin : next_state
    state_d = state_q;
    unique case (state_q)
      FETCH: begin
        if (flush_i) begin
          state_d = DRAIN;
        end else if (queue_full_i) begin
          state_d = STALL;
        end
      end
      STALL: begin
        // Leave once a pop has freed an entry
        if (flush_i) begin
          state_d = DRAIN;
        end else if (!queue_full_i) begin
          state_d = FETCH;
        end
      end
      DRAIN: begin
        // Another flush here just extends the drain
        if (!flush_i && !squash_i) begin
          state_d = FETCH;
        end
      end
      default: begin
        state_d = FETCH;
      end
    endcase
  end

  // State register
  always_ff @(posedge clk_i or negedge rst_ni) begin : state_reg
    if (!rst_ni) begin
      state_q <= FETCH;
    end else begin
      state_q <= state_d;
    end
  end

  // Full check also covers the cycle the queue fills
  assign issue_ok_o = (state_q == FETCH) & ~queue_full_i;

endmodule

/* src/inflight_cnt.sv */
// ---------------------------------------------------------
// Outstanding request counter with a squash count
// Responses to pre-flush requests are flagged for dropping
// ---------------------------------------------------------

`timescale 1ns/10ps

module inflight_cnt (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic accept_i,
  input  logic rvalid_i,
  input  logic flush_i,
  output logic squash_o
);

  import fetch_pkg::*;

  iq_cnt_t out_q;
  iq_cnt_t squash_q;
  logic    rsp_live;
  logic    rsp_dead;

  // Responses drain the squash count first, in order
  assign squash_o = (squash_q != '0);
  assign rsp_dead = rvalid_i & squash_o;
  assign rsp_live = rvalid_i & ~squash_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin : cnt_reg
    if (!rst_ni) begin
      out_q    <= '0;
      squash_q <= '0;
    end else if (flush_i) begin
      // Everything still in flight becomes stale
      // Response in this cycle already retires one of them
      squash_q <= squash_q + out_q - iq_cnt_t'(rvalid_i);
      out_q    <= '0;
    end else begin
      out_q    <= out_q + iq_cnt_t'(accept_i) - iq_cnt_t'(rsp_live);
      squash_q <= squash_q - iq_cnt_t'(rsp_dead);
    end
  end

endmodule

/* src/instr_queue.sv */
// ---------------------------------------------------------
// In-order fetch queue between memory and decode
// Entry reserved at request, filled at response, popped
// ---------------------------------------------------------

`timescale 1ns/10ps

module instr_queue (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    reserve_i,
  input  core_cfg_pkg::addr_t     pc_i,
  input  fetch_pkg::pred_t        pred_i,
  input  logic                    fill_i,
  input  core_cfg_pkg::instr_t    instr_i,
  input  logic                    pop_i,
  input  logic                    flush_i,
  output logic                    full_o,
  output logic                    valid_o,
  output fetch_pkg::fetch_entry_t entry_o
);

  import core_cfg_pkg::*;
  import fetch_pkg::*;

  // Payload storage
  addr_t  pc_q    [IQ_DEPTH];
  pred_t  pred_q  [IQ_DEPTH];
  instr_t instr_q [IQ_DEPTH];

  logic    [IQ_DEPTH-1:0] filled_q;
  iq_ptr_t rsv_ptr_q;
  iq_ptr_t fill_ptr_q;
  iq_ptr_t pop_ptr_q;
  iq_cnt_t count_q;
  logic    pop_ok;

  // Head is visible once its word has arrived
  assign valid_o = filled_q[pop_ptr_q];
  // Pops on an empty head are ignored
  assign pop_ok  = pop_i & valid_o;
  // Reserved entries count, filled or not
  assign full_o  = (count_q == iq_cnt_t'(IQ_DEPTH));

  // ---------------------------------------------------------
  // Pointers and occupancy
  // ---------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin : ctrl_reg
    if (!rst_ni) begin
      rsv_ptr_q  <= '0;
      fill_ptr_q <= '0;
      pop_ptr_q  <= '0;
      count_q    <= '0;
      filled_q   <= '0;
    end else if (flush_i) begin
      rsv_ptr_q  <= '0;
      fill_ptr_q <= '0;
      pop_ptr_q  <= '0;
      count_q    <= '0;
      filled_q   <= '0;
    end else begin
      if (reserve_i) begin
        rsv_ptr_q <= rsv_ptr_q + iq_ptr_t'(1);
      end
      // Fill and pop never touch the same slot
      if (fill_i) begin
        fill_ptr_q           <= fill_ptr_q + iq_ptr_t'(1);
        filled_q[fill_ptr_q] <= 1'b1;
      end
      if (pop_ok) begin
        pop_ptr_q           <= pop_ptr_q + iq_ptr_t'(1);
        filled_q[pop_ptr_q] <= 1'b0;
      end
      count_q <= count_q + iq_cnt_t'(reserve_i) - iq_cnt_t'(pop_ok);
    end
  end

  // ---------------------------------------------------------
  // Payload
  // ---------------------------------------------------------

  always_ff @(posedge clk_i) begin : data_reg
    if (reserve_i) begin
      pc_q[rsv_ptr_q]   <= pc_i;
      pred_q[rsv_ptr_q] <= pred_i;
    end
    if (fill_i) begin
      instr_q[fill_ptr_q] <= instr_i;
    end
  end

  // Oldest entry to decode
  assign entry_o.pc    = pc_q[pop_ptr_q];
  assign entry_o.instr = instr_q[pop_ptr_q];
  assign entry_o.pred  = pred_q[pop_ptr_q];

endmodule

/* src/fetch_unit.sv */
// ---------------------------------------------------------
// Instruction fetch front end top level
// Drives the memory port and feeds decode in program order
// ---------------------------------------------------------

`timescale 1ns/10ps

module fetch_unit (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Commit stage redirect
  input  logic                    comm_except_raised_i,
  input  core_cfg_pkg::addr_t     comm_except_pc_i,
  // Branch unit
  input  logic                    bu_res_valid_i,
  input  fetch_pkg::resolution_t  bu_res_i,
  output logic                    bu_ready_o,
  // Instruction memory
  output logic                    mem_req_o,
  output core_cfg_pkg::addr_t     mem_addr_o,
  input  logic                    mem_ready_i,
  input  logic                    mem_rvalid_i,
  input  core_cfg_pkg::instr_t    mem_rdata_i,
  // Decode
  output logic                    instr_valid_o,
  output fetch_pkg::fetch_entry_t instr_o,
  input  logic                    instr_pop_i
);

  import core_cfg_pkg::*;
  import fetch_pkg::*;

  addr_t pc;
  pred_t pred;
  logic  pc_valid;
  logic  issue_ok;
  logic  accept;
  logic  flush;
  logic  fill;
  logic  squash;
  logic  queue_full;

  // ---------------------------------------------------------
  // Strobes
  // ---------------------------------------------------------

  // Exception or a valid mispredict
  assign flush      = comm_except_raised_i | (bu_res_valid_i & bu_res_i.mispredict);
  assign mem_req_o  = issue_ok & pc_valid;
  assign mem_addr_o = pc;
  // Request handshake
  assign accept     = mem_req_o & mem_ready_i;
  // Stale responses never reach the queue
  assign fill       = mem_rvalid_i & ~squash & ~flush;

  pc_gen u_pc_gen (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .comm_except_raised_i(comm_except_raised_i),
    .comm_except_pc_i    (comm_except_pc_i),
    .bu_res_valid_i      (bu_res_valid_i),
    .bu_res_i            (bu_res_i),
    .pred_i              (pred),
    .step_i              (accept),
    .mem_ready_i         (mem_ready_i),
    .valid_o             (pc_valid),
    .bu_ready_o          (bu_ready_o),
    .pc_o                (pc)
  );

  branch_pred u_branch_pred (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .pc_i          (pc),
    .pred_o        (pred),
    .bu_res_valid_i(bu_res_valid_i),
    .bu_res_i      (bu_res_i)
  );

  fetch_fsm u_fetch_fsm (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush),
    .queue_full_i(queue_full),
    .squash_i    (squash),
    .issue_ok_o  (issue_ok)
  );

  inflight_cnt u_inflight_cnt (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .accept_i(accept),
    .rvalid_i(mem_rvalid_i),
    .flush_i (flush),
    .squash_o(squash)
  );

  instr_queue u_instr_queue (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .reserve_i(accept),
    .pc_i     (pc),
    .pred_i   (pred),
    .fill_i   (fill),
    .instr_i  (mem_rdata_i),
    .pop_i    (instr_pop_i),
    .flush_i  (flush),
    .full_o   (queue_full),
    .valid_o  (instr_valid_o),
    .entry_o  (instr_o)
  );

endmodule

/* bench/fetch_unit_assertions.sv */
// ----------------------------------------------------------
// Port-level protocol assertions for the fetch front end
// Bound into fetch_unit, so every instance carries them
// ----------------------------------------------------------

`timescale 1ns/10ps

module fetch_unit_assertions (
  input logic                clk_i,
  input logic                rst_ni,
  input logic                mem_req_i,
  input logic                mem_ready_i,
  input core_cfg_pkg::addr_t mem_addr_i,
  input logic                queue_full_i,
  input logic                instr_valid_i,
  input logic                bu_ready_i
);

  // Address holds until the memory takes it
  addr_hold : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (mem_req_i && !mem_ready_i) |=> $stable(mem_addr_i)
  ) else $error("mem_addr_o changed while a request was waiting");

  // No request once every queue entry is reserved
  no_req_when_full : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    queue_full_i |-> !mem_req_i
  ) else $error("mem_req_o raised while the queue is full");

  // Control outputs always driven
  outputs_known : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !$isunknown({mem_req_i, mem_addr_i, instr_valid_i, bu_ready_i})
  ) else $error("unknown value on a fetch_unit output");

endmodule

bind fetch_unit fetch_unit_assertions u_assertions (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .mem_req_i    (mem_req_o),
  .mem_ready_i  (mem_ready_i),
  .mem_addr_i   (mem_addr_o),
  .queue_full_i (queue_full),
  .instr_valid_i(instr_valid_o),
  .bu_ready_i   (bu_ready_o)
);

/* bench/tb_fetch_unit.sv */
// ----------------------------------------------------------
// Directed testbench for the fetch front end
// Memory model, reference predictor, decode checker, tests
// ----------------------------------------------------------

`timescale 1ns/10ps

module tb_fetch_unit;

  import core_cfg_pkg::*;
  import fetch_pkg::*;

  localparam int unsigned SEED    = 91265;
  localparam int unsigned CLK_NS  = 8;
  localparam int unsigned N_SEQ   = 12;
  localparam int unsigned N_BP    = 16;
  localparam int unsigned N_MIS   = 8;
  localparam int unsigned N_EXC   = 8;
  localparam int unsigned N_PRED  = 10;
  localparam int unsigned N_STALL = 8;
  // Partial streams before each redirect
  localparam int unsigned N_LEAD  = 6;
  localparam int unsigned N_TOTAL = N_SEQ + N_BP + 2 * N_MIS + N_EXC + N_PRED + N_STALL
                                    + 3 * N_LEAD;
  // Generous per-entry budget under random ready and latency
  localparam int unsigned WATCHDOG_CYCLES = N_TOTAL * 40 + 600;

  logic         clk_i;
  logic         rst_ni;
  logic         comm_except_raised_i;
  addr_t        comm_except_pc_i;
  logic         bu_res_valid_i;
  resolution_t  bu_res_i;
  logic         bu_ready_o;
  logic         mem_req_o;
  addr_t        mem_addr_o;
  logic         mem_ready_i;
  logic         mem_rvalid_i;
  instr_t       mem_rdata_i;
  logic         instr_valid_o;
  fetch_entry_t instr_o;
  logic         instr_pop_i;

  // Expected delivery order and the address after its tail
  addr_t       exp_q[$];
  addr_t       tail_pc;
  // Restart point read by the checker on a flush
  addr_t       redir_pc;
  int unsigned redir_len;
  // Reference predictor
  bp_cnt_t     ref_cnt   [16];
  logic        ref_valid [16];
  addr_t       ref_tgt   [16];
  // Memory model state
  instr_t      rsp_data[$];
  int unsigned rsp_due[$];
  int unsigned cyc;
  int unsigned last_due;
  logic        rand_ready;
  logic        pop_en;
  // Addresses accepted since the last flush, oldest first
  addr_t       acc_q[$];

  fetch_unit u_dut (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .comm_except_raised_i(comm_except_raised_i),
    .comm_except_pc_i    (comm_except_pc_i),
    .bu_res_valid_i      (bu_res_valid_i),
    .bu_res_i            (bu_res_i),
    .bu_ready_o          (bu_ready_o),
    .mem_req_o           (mem_req_o),
    .mem_addr_o          (mem_addr_o),
    .mem_ready_i         (mem_ready_i),
    .mem_rvalid_i        (mem_rvalid_i),
    .mem_rdata_i         (mem_rdata_i),
    .instr_valid_o       (instr_valid_o),
    .instr_o             (instr_o),
    .instr_pop_i         (instr_pop_i)
  );

  initial begin : clk_gen
    clk_i = 1'b0;
    forever #(CLK_NS / 2) clk_i = ~clk_i;
  end

  // ----------------------------------------------------------
  // Checking helpers
  // ----------------------------------------------------------

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
      $display("STATUS: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("STATUS: FAIL");
    $fatal(1, "run aborted");
  endtask

  // Taken needs a trained entry with counter at 2 or 3
  function automatic logic predicts_taken(input addr_t a);
    return ref_valid[a[5:2]] && (ref_cnt[a[5:2]] >= 2'd2);
  endfunction

  function automatic addr_t next_addr(input addr_t a);
    return predicts_taken(a) ? ref_tgt[a[5:2]] : a + 64'd4;
  endfunction

  function automatic void train_ref(input resolution_t res);
    logic [3:0] idx;
    idx = res.pc[5:2];
    if (res.taken) begin
      if (ref_cnt[idx] != 2'd3) begin
        ref_cnt[idx] = ref_cnt[idx] + 2'd1;
      end
      ref_valid[idx] = 1'b1;
      ref_tgt[idx]   = res.target;
    end else if (ref_cnt[idx] != 2'd0) begin
      ref_cnt[idx] = ref_cnt[idx] - 2'd1;
    end
  endfunction

  function automatic void push_expected(input int unsigned n);
    for (int unsigned i = 0; i < n; i++) begin
      exp_q.push_back(tail_pc);
      tail_pc = next_addr(tail_pc);
    end
  endfunction

  function automatic resolution_t make_res(input addr_t pc, input addr_t target,
                                           input logic taken, input logic mis);
    resolution_t r;
    r.pc         = pc;
    r.target     = target;
    r.taken      = taken;
    r.mispredict = mis;
    return r;
  endfunction

  task automatic check_entry();
    addr_t  exp_pc;
    addr_t  acc_pc;
    instr_t exp_instr;
    if (exp_q.size() == 0) begin
      abort_run("decode received an entry beyond the expected stream");
    end else if (acc_q.size() == 0) begin
      abort_run("decode received an entry that was never requested from memory");
    end else begin
      exp_pc    = exp_q.pop_front();
      acc_pc    = acc_q.pop_front();
      exp_instr = ~exp_pc[31:0];
      check_eq("mem_addr_o", acc_pc, exp_pc);
      check_eq("instr_o.pc", instr_o.pc, exp_pc);
      check_eq("instr_o.instr", 64'(instr_o.instr), 64'(exp_instr));
      check_eq("instr_o.pred.taken", 64'(instr_o.pred.taken), 64'(predicts_taken(exp_pc)));
      if (predicts_taken(exp_pc)) begin
        check_eq("instr_o.pred.target", instr_o.pred.target, ref_tgt[exp_pc[5:2]]);
      end
    end
  endtask

  // ----------------------------------------------------------
  // Memory model and decode checker
  // ----------------------------------------------------------

  // In-order responses, 1 to 3 cycles after accept
  always @(posedge clk_i) begin : mem_model
    int unsigned due;
    cyc = cyc + 1;
    mem_rvalid_i <= 1'b0;
    if (rst_ni) begin
      if (mem_req_o && mem_ready_i) begin
        due = cyc + 1 + ($urandom % 3);
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        rsp_data.push_back(~mem_addr_o[31:0]);
        rsp_due.push_back(due);
      end
      if (rsp_due.size() != 0 && rsp_due[0] == cyc) begin
        mem_rvalid_i <= 1'b1;
        mem_rdata_i  <= rsp_data.pop_front();
        void'(rsp_due.pop_front());
      end
      mem_ready_i <= rand_ready ? (($urandom % 4) != 0) : 1'b1;
    end
  end

  // Pops only while expectations remain
  always @(posedge clk_i) begin : decode_check
    logic flush_now;
    flush_now = comm_except_raised_i | (bu_res_valid_i & bu_res_i.mispredict);
    if (rst_ni) begin
      check_eq("bu_ready_o", 64'(bu_ready_o), 64'(mem_ready_i));
      if (bu_res_valid_i) begin
        train_ref(bu_res_i);
      end
      if (flush_now) begin
        // Nothing fetched before the redirect may show up
        exp_q.delete();
        acc_q.delete();
        tail_pc = redir_pc;
        push_expected(redir_len);
      end else begin
        if (mem_req_o && mem_ready_i) begin
          acc_q.push_back(mem_addr_o);
        end
        if (instr_pop_i && instr_valid_o) begin
          check_entry();
        end
      end
    end
    instr_pop_i <= pop_en && (exp_q.size() != 0);
  end

  // ----------------------------------------------------------
  // Stimulus tasks
  // ----------------------------------------------------------

  task automatic drive_redirect(input logic exc, input addr_t exc_pc, input logic res_v,
                                input resolution_t res, input addr_t restart,
                                input int unsigned n);
    @(negedge clk_i);
    redir_pc  = restart;
    redir_len = n;
    @(posedge clk_i);
    comm_except_raised_i <= exc;
    comm_except_pc_i     <= exc_pc;
    bu_res_valid_i       <= res_v;
    bu_res_i             <= res;
    @(posedge clk_i);
    comm_except_raised_i <= 1'b0;
    bu_res_valid_i       <= 1'b0;
  endtask

  task automatic wait_drained();
    do begin
      @(negedge clk_i);
    end while (exp_q.size() != 0);
  endtask

  // Stream running with requests still in flight
  task automatic stream_some(input int unsigned n);
    @(negedge clk_i);
    push_expected(n);
    while (exp_q.size() > n - 2) begin
      @(negedge clk_i);
    end
  endtask

  task automatic test_sequential();
    @(negedge clk_i);
    rand_ready = 1'b0;
    push_expected(N_SEQ);
    wait_drained();
  endtask

  task automatic test_backpressure();
    @(negedge clk_i);
    rand_ready = 1'b1;
    push_expected(N_BP);
    wait_drained();
  endtask

  task automatic test_mispredict();
    // Taken, resumes at the target
    stream_some(N_LEAD);
    drive_redirect(1'b0, '0, 1'b1, make_res(64'h8000_0104, 64'h8000_0240, 1'b1, 1'b1),
                   64'h8000_0240, N_MIS);
    wait_drained();
    // Not taken, resumes after the branch
    stream_some(N_LEAD);
    drive_redirect(1'b0, '0, 1'b1, make_res(64'h8000_0304, 64'h8000_0f00, 1'b0, 1'b1),
                   64'h8000_0304 + 64'd4, N_MIS);
    wait_drained();
  endtask

  task automatic test_exception();
    stream_some(N_LEAD);
    drive_redirect(1'b1, 64'h8000_0400, 1'b1,
                   make_res(64'h8000_0508, 64'h8000_0a00, 1'b0, 1'b1),
                   64'h8000_0400, N_EXC);
    wait_drained();
  endtask

  task automatic test_prediction();
    // Two taken resolutions at A, no redirect
    repeat (2) begin
      drive_redirect(1'b0, '0, 1'b1, make_res(64'h8000_0710, 64'h8000_0800, 1'b1, 1'b0),
                     '0, 0);
    end
    // Re-enter just ahead of A
    drive_redirect(1'b1, 64'h8000_0708, 1'b0, '0, 64'h8000_0708, N_PRED);
    wait_drained();
  endtask

  task automatic test_decode_stall();
    int unsigned waited;
    @(negedge clk_i);
    pop_en = 1'b0;
    push_expected(N_STALL);
    waited = 0;
    while (acc_q.size() != IQ_DEPTH && waited < 200) begin
      @(negedge clk_i);
      waited++;
    end
    repeat (8) @(negedge clk_i);
    check_eq("reserved entries", 64'(acc_q.size()), 64'(IQ_DEPTH));
    check_eq("mem_req_o", 64'(mem_req_o), 64'd0);
    pop_en = 1'b1;
    wait_drained();
  endtask

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_NS);
    abort_run("watchdog expired before the tests completed");
  end

  initial begin : run_tests
    void'($urandom(SEED));
    rst_ni               = 1'b0;
    comm_except_raised_i = 1'b0;
    comm_except_pc_i     = '0;
    bu_res_valid_i       = 1'b0;
    bu_res_i             = '0;
    mem_ready_i          = 1'b0;
    mem_rvalid_i         = 1'b0;
    mem_rdata_i          = '0;
    instr_pop_i          = 1'b0;
    rand_ready           = 1'b0;
    pop_en               = 1'b1;
    cyc                  = 0;
    last_due             = 0;
    tail_pc              = BOOT_PC;
    redir_pc             = BOOT_PC;
    redir_len            = 0;
    for (int i = 0; i < 16; i++) begin
      ref_cnt[i]   = 2'd1;
      ref_valid[i] = 1'b0;
      ref_tgt[i]   = '0;
    end
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    test_sequential();
    test_backpressure();
    test_mispredict();
    test_exception();
    test_prediction();
    test_decode_stall();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

/* list.f */
src/core_cfg_pkg.sv
src/fetch_pkg.sv
src/pc_gen.sv
src/branch_pred.sv
src/fetch_fsm.sv
src/inflight_cnt.sv
src/instr_queue.sv
src/fetch_unit.sv
bench/fetch_unit_assertions.sv
bench/tb_fetch_unit.sv

/* run.sh */
#!/bin/sh
# Build and run the fetch unit testbench; passes only if the pass line is printed
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert --top-module tb_fetch_unit -f list.f \
  && ./obj_dir/Vtb_fetch_unit | tee /dev/stderr | grep -q "STATUS: PASS" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
